// File: bench/tb_ref.svh
// Reference model for the LSU testbench, shadow memory with store lane and load extension rules

xlen_t shadow_mem [MEM_WORDS];

function automatic bit in_range(input addr_t a);
  return (a >> 2) < MEM_WORDS;
endfunction

function automatic int width_bytes(input lsu_w_e w);
  case (w)
    RV_LSU_B, RV_LSU_BU: return 1;
    RV_LSU_H, RV_LSU_HU: return 2;
    default:             return 4;
  endcase
endfunction

// Bytes land from the offset upward, anything past lane 3 is dropped
function automatic void ref_store(input addr_t a, input lsu_w_e w, input xlen_t d);
  int idx;
  int lane;
  idx = a >> 2;
  if (in_range(a)) begin
    for (int k = 0; k < width_bytes(w); k++) begin
      lane = a[1:0] + k;
      if (lane < 4) begin
        shadow_mem[idx][8*lane +: 8] = d[8*k +: 8];
      end
    end
  end
endfunction

// Error region reads back as zero
function automatic xlen_t ref_load(input addr_t a, input lsu_w_e w);
  xlen_t       word;
  logic [7:0]  b;
  logic [15:0] h;
  int          off;
  off  = a[1:0];
  word = in_range(a) ? shadow_mem[a >> 2] : '0;
  b    = word[8*off +: 8];
  h    = word[8*off +: 16];
  case (w)
    RV_LSU_B:  return {{24{b[7]}}, b};
    RV_LSU_BU: return {24'h000000, b};
    RV_LSU_H:  return {{16{h[15]}}, h};
    RV_LSU_HU: return {16'h0000, h};
    default:   return word;
  endcase
endfunction

// File: bench/tb_lsu_top.sv
// Testbench for the LSU top, drives loads and stores and checks them against a reference model
`timescale 1ns/100ps

module tb_lsu_top
  import lsu_pkg::*;
();

  localparam int MEM_WORDS   = 256;
  localparam int WAIT_STATES = 2;
  localparam int TIMEOUT     = 200;

  // One outstanding load as the checker expects it
  typedef struct packed {
    xlen_t data;
    logic  err;
    addr_t addr;
  } exp_ld_t;

  logic         clk = 1'b0;
  logic         rst_n_i = 1'b0;
  s_lsu_op_t    lsu_i = '0;
  logic         lsu_bp_o;
  s_lsu_op_t    wb_lsu_o;
  xlen_t        lsu_data_o;
  logic         lsu_data_valid_o;
  s_trap_info_t trap_st_o;
  s_trap_info_t trap_ld_o;

  exp_ld_t ld_q[$];
  addr_t   st_trap_q[$];
  exp_ld_t got;
  addr_t   got_addr;
  string   cur_test = "none";
  int      seed = 80607;
  int      err_cnt = 0;
  int      chk_cnt = 0;
  int      test_cnt = 0;
  int      test_err_base = 0;
  lsu_w_e  ext_w [4] = '{RV_LSU_B, RV_LSU_BU, RV_LSU_H, RV_LSU_HU};

  `include "tb_ref.svh"

  lsu_top #(
    .MEM_WORDS   (MEM_WORDS),
    .WAIT_STATES (WAIT_STATES)
  ) lsu_top_i (
    .clk              (clk),
    .rst_n_i          (rst_n_i),
    .lsu_i            (lsu_i),
    .lsu_bp_o         (lsu_bp_o),
    .wb_lsu_o         (wb_lsu_o),
    .lsu_data_o       (lsu_data_o),
    .lsu_data_valid_o (lsu_data_valid_o),
    .trap_st_o        (trap_st_o),
    .trap_ld_o        (trap_ld_o)
  );

  always #4 clk = ~clk;

  // Results are compared in issue order
  always @(posedge clk) begin
    if (rst_n_i && lsu_data_valid_o && wb_lsu_o.op_typ == LSU_LOAD) begin
      chk_cnt++;
      if (ld_q.size() == 0) begin
        $display("Load result with no load outstanding in %s", cur_test);
        err_cnt++;
      end else begin
        got = ld_q.pop_front();
        if (lsu_data_o !== got.data) begin
          $display("Mismatch %s load data: expected %h, actual %h", cur_test, got.data,
                   lsu_data_o);
          err_cnt++;
        end
        if (trap_ld_o.active !== got.err) begin
          $display("Mismatch %s load trap: expected %b, actual %b", cur_test, got.err,
                   trap_ld_o.active);
          err_cnt++;
        end
        if (got.err && trap_ld_o.addr !== got.addr) begin
          $display("Mismatch %s load trap addr: expected %h, actual %h", cur_test, got.addr,
                   trap_ld_o.addr);
          err_cnt++;
        end
      end
    end
    if (rst_n_i && trap_st_o.active) begin
      chk_cnt++;
      if (st_trap_q.size() == 0) begin
        $display("Store trap with no failing store outstanding in %s", cur_test);
        err_cnt++;
      end else begin
        got_addr = st_trap_q.pop_front();
        if (trap_st_o.addr !== got_addr) begin
          $display("Mismatch %s store trap addr: expected %h, actual %h", cur_test, got_addr,
                   trap_st_o.addr);
          err_cnt++;
        end
      end
    end
  end

  task automatic timeout_fail(input string what);
    $display("Timeout waiting for %s in %s", what, cur_test);
    $display("Done: errors found");
    $finish;
  endtask

  task automatic check_reset_state();
    chk_cnt++;
    if (lsu_bp_o !== 1'b0 || trap_st_o.active !== 1'b0 || trap_ld_o.active !== 1'b0 ||
        lsu_data_valid_o !== 1'b0 || wb_lsu_o.op_typ !== NO_LSU) begin
      $display("Outputs are not idle around reset in %s", cur_test);
      err_cnt++;
    end
  endtask

  // Present one op and hold it until back-pressure is seen low
  task automatic issue_op(input lsu_typ_e typ, input lsu_w_e w, input addr_t a, input xlen_t d);
    s_lsu_op_t op;
    exp_ld_t   e;
    int        t;
    op.op_typ = typ;
    op.width  = w;
    op.addr   = a;
    op.wdata  = d;
    if (typ == LSU_LOAD) begin
      e.data = ref_load(a, w);
      e.err  = !in_range(a);
      e.addr = a;
      ld_q.push_back(e);
    end else begin
      if (!in_range(a)) begin
        st_trap_q.push_back(a);
      end
      ref_store(a, w, d);
    end
    lsu_i <= op;
    t = 0;
    @(posedge clk);
    while (lsu_bp_o) begin
      if (t == TIMEOUT) timeout_fail("back-pressure to drop");
      @(posedge clk);
      t++;
    end
  endtask

  task automatic store_op(input lsu_w_e w, input addr_t a, input xlen_t d);
    issue_op(LSU_STORE, w, a, d);
  endtask

  task automatic load_op(input lsu_w_e w, input addr_t a);
    issue_op(LSU_LOAD, w, a, '0);
  endtask

  task automatic start_test(input string name);
    cur_test      = name;
    test_err_base = err_cnt;
  endtask

  task automatic end_test();
    int t;
    lsu_i <= s_lsu_op_t'('0);
    t = 0;
    @(posedge clk);
    while (lsu_bp_o || ld_q.size() != 0 || st_trap_q.size() != 0) begin
      if (t == TIMEOUT) timeout_fail("outstanding results to drain");
      @(posedge clk);
      t++;
    end
    test_cnt++;
    $display("Test %s finished, %0d errors", cur_test, err_cnt - test_err_base);
  endtask

  initial begin
    addr_t  a;
    xlen_t  d;
    lsu_w_e w;
    int     off;

    start_test("reset_state");
    for (int i = 0; i < 8; i++) begin
      @(posedge clk);
      // First edge still shows pre-reset state
      if (i > 0) check_reset_state();
    end
    rst_n_i <= 1'b1;
    @(posedge clk);
    check_reset_state();
    end_test();

    start_test("word_round_trip");
    for (int k = 0; k < 4; k++) begin
      a = ($unsigned($random(seed)) % MEM_WORDS) << 2;
      store_op(RV_LSU_W, a, $random(seed));
      load_op(RV_LSU_W, a);
    end
    end_test();

    start_test("byte_half_store");
    a = 32'd30 << 2;
    store_op(RV_LSU_W, a, $random(seed));
    for (int o = 0; o < 4; o++) begin
      store_op(RV_LSU_B, a + o, $random(seed));
      load_op(RV_LSU_W, a);
    end
    for (int o = 0; o < 4; o += 2) begin
      store_op(RV_LSU_H, a + o, $random(seed));
      load_op(RV_LSU_W, a);
    end
    end_test();

    start_test("load_extend");
    a = 32'd20 << 2;
    for (int k = 0; k < 2; k++) begin
      // Fixed word has both sign polarities in its bytes and halfwords
      d = (k == 0) ? 32'h7f80_ff01 : $random(seed);
      store_op(RV_LSU_W, a, d);
      for (int j = 0; j < 4; j++) begin
        for (int o = 0; o < 4; o++) begin
          if (width_bytes(ext_w[j]) == 1 || o % 2 == 0) begin
            load_op(ext_w[j], a + o);
          end
        end
      end
    end
    end_test();

    start_test("burst");
    for (int k = 0; k < 8; k++) begin
      store_op(RV_LSU_W, (40 + k) << 2, $random(seed));
    end
    for (int k = 0; k < 24; k++) begin
      w   = lsu_w_e'($unsigned($random(seed)) % 5);
      off = $unsigned($random(seed)) % 4;
      if (width_bytes(w) == 4) begin
        off = 0;
      end else if (width_bytes(w) == 2) begin
        off = off & 2;
      end
      a = ((40 + $unsigned($random(seed)) % 8) << 2) + off;
      if ($random(seed) & 1) begin
        store_op(w, a, $random(seed));
      end else begin
        load_op(w, a);
      end
    end
    end_test();

    start_test("error_region");
    store_op(RV_LSU_W, 32'd3 << 2, $random(seed));
    load_op(RV_LSU_W, MEM_WORDS << 2);
    // Would alias word 3 if the write were not blocked
    store_op(RV_LSU_W, (MEM_WORDS + 3) << 2, $random(seed));
    load_op(RV_LSU_W, 32'd3 << 2);
    end_test();

    $display("%0d tests, %0d checks, %0d errors", test_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: flist.f
+incdir+bench
hdl/lsu_pkg.sv
hdl/wait_cnt.sv
hdl/st_align.sv
hdl/ld_align.sv
hdl/lsu.sv
hdl/dmem_slave.sv
hdl/lsu_top.sv
bench/tb_lsu_top.sv

// File: hdl/dmem_slave.sv
// Data memory slave, word storage behind the split-channel bus with wait states and an error region
`timescale 1ns/100ps

module dmem_slave
  import lsu_pkg::*;
#(
  parameter int MEM_WORDS   = 256,
  parameter int WAIT_STATES = 2
) (
  input  logic       clk,
  input  logic       rst_n_i,
  input  s_cb_mosi_t cb_mosi_i,
  output s_cb_miso_t cb_miso_o
);

  localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  typedef enum logic [2:0] {
    IDLE,
    RD_WAIT,
    RD_DATA,
    WR_WAIT,
    WR_DATA,
    WR_RESP
  } dmem_st_e;

  dmem_st_e         state_ff;
  dmem_st_e         next_state;
  logic             cnt_load;
  logic             wait_done;
  addr_t            cap_addr;
  addr_t            addr_ff;
  logic             err_ff;
  xlen_t            rdata_ff;
  logic [IDX_W-1:0] idx;

  xlen_t mem [MEM_WORDS];

  wait_cnt #(
    .WAIT_STATES (WAIT_STATES)
  ) u_wait_cnt (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .load_i  (cnt_load),
    .done_o  (wait_done)
  );

  always_comb begin
    // Reads win if both address channels are valid
    cap_addr   = cb_mosi_i.rd_addr_valid ? cb_mosi_i.rd_addr : cb_mosi_i.wr_addr;
    idx        = addr_ff[IDX_W+1:2];
    next_state = state_ff;
    cnt_load   = 1'b0;

    case (state_ff)
      IDLE: begin
        if (cb_mosi_i.rd_addr_valid) begin
          next_state = RD_WAIT;
          cnt_load   = 1'b1;
        end else if (cb_mosi_i.wr_addr_valid) begin
          next_state = WR_WAIT;
          cnt_load   = 1'b1;
        end
      end
      RD_WAIT: if (wait_done) next_state = RD_DATA;
      RD_DATA: if (cb_mosi_i.rd_ready) next_state = IDLE;
      WR_WAIT: if (wait_done) next_state = WR_DATA;
      WR_DATA: if (cb_mosi_i.wr_data_valid) next_state = WR_RESP;
      WR_RESP: if (cb_mosi_i.wr_resp_ready) next_state = IDLE;
      default: next_state = IDLE;
    endcase

    cb_miso_o               = s_cb_miso_t'('0);
    cb_miso_o.rd_addr_ready = (state_ff == IDLE);
    cb_miso_o.wr_addr_ready = (state_ff == IDLE);
    cb_miso_o.rd_data       = rdata_ff;
    cb_miso_o.rd_resp       = err_ff ? CB_SLVERR : CB_OKAY;
    cb_miso_o.rd_valid      = (state_ff == RD_DATA);
    cb_miso_o.wr_data_ready = (state_ff == WR_DATA);
    cb_miso_o.wr_resp_error = err_ff ? CB_SLVERR : CB_OKAY;
    cb_miso_o.wr_resp_valid = (state_ff == WR_RESP);
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_ff <= IDLE;
    end else begin
      state_ff <= next_state;
    end
  end

  // Address and error flag latched at address acceptance
  always_ff @(posedge clk) begin
    if (cnt_load) begin
      addr_ff <= cap_addr;
      err_ff  <= ({2'b00, cap_addr[31:2]} >= addr_t'(MEM_WORDS));
    end
  end

  always_ff @(posedge clk) begin
    if (state_ff == RD_WAIT && wait_done) begin
      rdata_ff <= err_ff ? '0 : mem[idx];
    end
  end

  // Lane writes, nothing lands in the error region
  always_ff @(posedge clk) begin
    if (state_ff == WR_DATA && cb_mosi_i.wr_data_valid && !err_ff) begin
      for (int i = 0; i < 4; i++) begin
        if (cb_mosi_i.wr_strobe[i]) begin
          mem[idx][8*i +: 8] <= cb_mosi_i.wr_data[8*i +: 8];
        end
      end
    end
  end

  a_no_wdata_in_idle: assert property (@(posedge clk) disable iff (!rst_n_i)
    cb_mosi_i.wr_data_valid |-> (state_ff != IDLE));

endmodule

// File: hdl/ld_align.sv
// Load aligner, picks the addressed byte or halfword and extends it for write-back
`timescale 1ns/100ps

module ld_align
  import lsu_pkg::*;
(
  input  lsu_w_e     width_i,
  input  logic [1:0] offset_i,
  input  xlen_t      rdata_i,
  output xlen_t      data_o
);

  xlen_t shifted;

  always_comb begin
    // Bring the addressed lane down to bit 0
    shifted = rdata_i >> {offset_i, 3'b000};

    case (width_i)
      RV_LSU_B: begin
        data_o = {{24{shifted[7]}}, shifted[7:0]};
      end
      RV_LSU_BU: begin
        data_o = {24'h000000, shifted[7:0]};
      end
      RV_LSU_H: begin
        data_o = {{16{shifted[15]}}, shifted[15:0]};
      end
      RV_LSU_HU: begin
        data_o = {16'h0000, shifted[15:0]};
      end
      default: begin
        // Full word, no shift
        data_o = rdata_i;
      end
    endcase
  end

endmodule

// File: hdl/lsu.sv
// Load/store unit that issues two-phase bus requests with back-pressure and bus error traps
`timescale 1ns/100ps

module lsu
  import lsu_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n_i,
  // Execute stage
  input  s_lsu_op_t    lsu_i,
  output logic         lsu_bp_o,
  // Write-back
  output s_lsu_op_t    wb_lsu_o,
  // Data bus
  output s_cb_mosi_t   data_cb_mosi_o,
  input  s_cb_miso_t   data_cb_miso_i,
  // Access faults
  output s_trap_info_t trap_st_o,
  output s_trap_info_t trap_ld_o
);

  s_lsu_op_t lsu_ff;
  s_lsu_op_t next_lsu;
  logic      req_ff;
  logic      next_req;
  logic      wr_resp_ff;
  logic      next_wresp;
  addr_t     st_addr_ff;

  logic      new_txn;
  logic      rd_txn;
  logic      wr_dp;
  logic      addr_en;
  logic      wr_xfer;
  logic      bp_addr;
  logic      bp_data;
  logic      bp_wr_resp;

  strb_t     st_strb;
  xlen_t     st_wdata;

  st_align u_st_align (
    .width_i  (lsu_ff.width),
    .offset_i (lsu_ff.addr[1:0]),
    .wdata_i  (lsu_ff.wdata),
    .strb_o   (st_strb),
    .wdata_o  (st_wdata)
  );

  always_comb begin
    new_txn = (lsu_i.op_typ != NO_LSU);
    rd_txn  = (lsu_i.op_typ == LSU_LOAD);
    wr_dp   = (lsu_ff.op_typ == LSU_STORE);
    wr_xfer = req_ff && wr_dp && data_cb_miso_i.wr_data_ready;

    // Stall sources
    bp_addr    = new_txn && (rd_txn ? !data_cb_miso_i.rd_addr_ready :
                                      !data_cb_miso_i.wr_addr_ready);
    bp_data    = req_ff && (wr_dp ? !data_cb_miso_i.wr_data_ready :
                                    !data_cb_miso_i.rd_valid);
    bp_wr_resp = wr_resp_ff && !data_cb_miso_i.wr_resp_valid;
    lsu_bp_o   = bp_addr || bp_data || bp_wr_resp;

    // No new address while a data phase or a write response is open
    addr_en = new_txn && !bp_data && !wr_resp_ff;

    data_cb_mosi_o               = s_cb_mosi_t'('0);
    data_cb_mosi_o.rd_ready      = 1'b1;
    data_cb_mosi_o.wr_resp_ready = 1'b1;

    if (addr_en) begin
      if (rd_txn) begin
        data_cb_mosi_o.rd_addr       = {lsu_i.addr[31:2], 2'b00};
        data_cb_mosi_o.rd_addr_valid = 1'b1;
      end else begin
        data_cb_mosi_o.wr_addr       = {lsu_i.addr[31:2], 2'b00};
        data_cb_mosi_o.wr_addr_valid = 1'b1;
      end
    end

    if (req_ff && wr_dp) begin
      data_cb_mosi_o.wr_data       = st_wdata;
      data_cb_mosi_o.wr_strobe     = st_strb;
      data_cb_mosi_o.wr_data_valid = 1'b1;
    end

    // Advance into the data phase, or close a finished one that is stuck on a busy address
    next_lsu = lsu_ff;
    next_req = req_ff;
    if (!lsu_bp_o) begin
      next_lsu = lsu_i;
      next_req = new_txn;
    end else if (req_ff && !bp_data) begin
      next_req = 1'b0;
    end

    next_wresp = wr_resp_ff ? !data_cb_miso_i.wr_resp_valid : wr_xfer;

    trap_st_o        = s_trap_info_t'('0);
    trap_st_o.active = data_cb_miso_i.wr_resp_valid &&
                       (data_cb_miso_i.wr_resp_error != CB_OKAY);
    trap_st_o.addr   = st_addr_ff;

    trap_ld_o        = s_trap_info_t'('0);
    trap_ld_o.active = data_cb_miso_i.rd_valid && (data_cb_miso_i.rd_resp != CB_OKAY);
    trap_ld_o.addr   = lsu_ff.addr;

    wb_lsu_o = lsu_ff;
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      lsu_ff     <= s_lsu_op_t'('0);
      req_ff     <= 1'b0;
      wr_resp_ff <= 1'b0;
    end else begin
      lsu_ff     <= next_lsu;
      req_ff     <= next_req;
      wr_resp_ff <= next_wresp;
    end
  end

  // The op register may move on before the response, so keep the store address
  always_ff @(posedge clk) begin
    if (wr_xfer) begin
      st_addr_ff <= lsu_ff.addr;
    end
  end

  // An op that arrives while a store awaits its response must not slip past without an address
  a_hold_op_in_wresp: assert property (@(posedge clk) disable iff (!rst_n_i)
    (wr_resp_ff && new_txn) |-> lsu_bp_o);

  a_st_trap_on_resp: assert property (@(posedge clk) disable iff (!rst_n_i)
    trap_st_o.active |-> wr_resp_ff);

  a_ld_trap_on_resp: assert property (@(posedge clk) disable iff (!rst_n_i)
    trap_ld_o.active |-> (req_ff && lsu_ff.op_typ == LSU_LOAD));

endmodule

// File: hdl/lsu_pkg.sv
// LSU package with the data bus channel structs, the operation struct, enums and width types
package lsu_pkg;

  typedef logic [31:0] xlen_t;
  typedef logic [31:0] addr_t;
  typedef logic [3:0]  strb_t;

  // NO_LSU must stay at zero so a cleared op register means idle
  typedef enum logic [1:0] {
    NO_LSU    = 2'd0,
    LSU_LOAD  = 2'd1,
    LSU_STORE = 2'd2
  } lsu_typ_e;

  typedef enum logic [2:0] {
    RV_LSU_B  = 3'd0,
    RV_LSU_H  = 3'd1,
    RV_LSU_W  = 3'd2,
    RV_LSU_BU = 3'd3,
    RV_LSU_HU = 3'd4
  } lsu_w_e;

  typedef enum logic {
    CB_OKAY   = 1'b0,
    CB_SLVERR = 1'b1
  } cb_resp_e;

  // One load or store, from execute through to write-back
  typedef struct packed {
    lsu_typ_e op_typ;
    lsu_w_e   width;
    addr_t    addr;
    xlen_t    wdata;
  } s_lsu_op_t;

  // Master to slave
  typedef struct packed {
    addr_t    rd_addr;
    logic     rd_addr_valid;
    logic     rd_ready;
    addr_t    wr_addr;
    logic     wr_addr_valid;
    xlen_t    wr_data;
    strb_t    wr_strobe;
    logic     wr_data_valid;
    logic     wr_resp_ready;
  } s_cb_mosi_t;

  // Slave to master
  typedef struct packed {
    logic     rd_addr_ready;
    xlen_t    rd_data;
    cb_resp_e rd_resp;
    logic     rd_valid;
    logic     wr_addr_ready;
    logic     wr_data_ready;
    cb_resp_e wr_resp_error;
    logic     wr_resp_valid;
  } s_cb_miso_t;

  typedef struct packed {
    logic  active;
    addr_t addr;
  } s_trap_info_t;

endpackage

// File: hdl/lsu_top.sv
// LSU top, joins the load/store unit, the load aligner and the data memory slave
`timescale 1ns/100ps

module lsu_top
  import lsu_pkg::*;
#(
  parameter int MEM_WORDS   = 256,
  parameter int WAIT_STATES = 2
) (
  input  logic         clk,
  input  logic         rst_n_i,
  input  s_lsu_op_t    lsu_i,
  output logic         lsu_bp_o,
  output s_lsu_op_t    wb_lsu_o,
  output xlen_t        lsu_data_o,
  output logic         lsu_data_valid_o,
  output s_trap_info_t trap_st_o,
  output s_trap_info_t trap_ld_o
);

  s_cb_mosi_t data_cb_mosi;
  s_cb_miso_t data_cb_miso;

  lsu u_lsu (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .lsu_i          (lsu_i),
    .lsu_bp_o       (lsu_bp_o),
    .wb_lsu_o       (wb_lsu_o),
    .data_cb_mosi_o (data_cb_mosi),
    .data_cb_miso_i (data_cb_miso),
    .trap_st_o      (trap_st_o),
    .trap_ld_o      (trap_ld_o)
  );

  // Load result follows the op in its data phase
  ld_align u_ld_align (
    .width_i  (wb_lsu_o.width),
    .offset_i (wb_lsu_o.addr[1:0]),
    .rdata_i  (data_cb_miso.rd_data),
    .data_o   (lsu_data_o)
  );

  dmem_slave #(
    .MEM_WORDS   (MEM_WORDS),
    .WAIT_STATES (WAIT_STATES)
  ) u_dmem_slave (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .cb_mosi_i (data_cb_mosi),
    .cb_miso_o (data_cb_miso)
  );

  assign lsu_data_valid_o = data_cb_miso.rd_valid;

endmodule

// File: hdl/st_align.sv
// Store aligner, shifts write data to its byte lanes and builds the lane strobes
`timescale 1ns/100ps

module st_align
  import lsu_pkg::*;
(
  input  lsu_w_e     width_i,
  input  logic [1:0] offset_i,
  input  xlen_t      wdata_i,
  output strb_t      strb_o,
  output xlen_t      wdata_o
);

  strb_t base_strb;
  xlen_t shifted;

  always_comb begin
    case (width_i)
      RV_LSU_B,
      RV_LSU_BU: base_strb = 4'b0001;
      RV_LSU_H,
      RV_LSU_HU: base_strb = 4'b0011;
      default:   base_strb = 4'b1111;
    endcase

    // 4-bit result, lanes past 3 fall off the top
    strb_o  = base_strb << offset_i;
    shifted = wdata_i << {offset_i, 3'b000};

    // Unstrobed lanes are driven as zero
    for (int i = 0; i < 4; i++) begin
      wdata_o[8*i +: 8] = strb_o[i] ? shifted[8*i +: 8] : 8'h00;
    end
  end

endmodule

// File: hdl/wait_cnt.sv
// Wait-state counter, loadable down-counter flagging when the wait has elapsed
`timescale 1ns/100ps

module wait_cnt #(
  parameter int WAIT_STATES = 2
) (
  input  logic clk,
  input  logic rst_n_i,
  input  logic load_i,
  output logic done_o
);

  // At least one bit, so zero wait states still builds
  localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

  logic [CNT_W-1:0] cnt_ff;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      cnt_ff <= '0;
    end else if (load_i) begin
      cnt_ff <= CNT_W'(WAIT_STATES);
    end else if (cnt_ff != '0) begin
      cnt_ff <= cnt_ff - 1'b1;
    end
  end

  // High for as long as the count rests at zero
  assign done_o = (cnt_ff == '0);

endmodule

// File: run.sh
#!/bin/sh
# Build tb_lsu_top with Verilator, run it and look for the pass line in its output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_lsu_top -f flist.f \
  || { echo "Build failed"; exit 1; }
out=$(./obj_dir/Vtb_lsu_top)
echo "$out"
echo "$out" | grep -qx "Done: no errors" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
